// ==== fetch_pkg.sv ====
// fetch stage shared definitions
// bank geometry, buffer depth, reset vector, request and entry
// structs, and the opcode groups used by the early decode

`default_nettype none

package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////////////////////////
    localparam int NUM_BANKS          = 4;
    localparam int BANK_WORDS         = 64;
    localparam int BANK_ADDR_W        = 6;
    localparam int BANK_SEL_W         = 2;
    localparam int FETCH_BUFFER_DEPTH = 4;

    // count needs one extra state for full
    localparam int IB_COUNT_W = $clog2(FETCH_BUFFER_DEPTH + 1);
    localparam int IB_PTR_W   = $clog2(FETCH_BUFFER_DEPTH);

    // bank 1, word 0
    localparam logic [31:0] RESET_VEC = 32'h0000_0100;

    //////////////////////////////////////////////////////////////////////
    // opcode groups, instr[6:2]
    //////////////////////////////////////////////////////////////////////
    localparam logic [4:0] LUI_T       = 5'b01101;
    localparam logic [4:0] AUIPC_T     = 5'b00101;
    localparam logic [4:0] JAL_T       = 5'b11011;
    localparam logic [4:0] JALR_T      = 5'b11001;
    localparam logic [4:0] BRANCH_T    = 5'b11000;
    localparam logic [4:0] LOAD_T      = 5'b00000;
    localparam logic [4:0] STORE_T     = 5'b01000;
    localparam logic [4:0] ARITH_IMM_T = 5'b00100;
    localparam logic [4:0] ARITH_T     = 5'b01100;
    localparam logic [4:0] FENCE_T     = 5'b00011;
    localparam logic [4:0] SYSTEM_T    = 5'b11100;
    localparam logic [4:0] AMO_T       = 5'b01011;

    //////////////////////////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////////////////////////
    // read is a fetch, write is a host load
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [BANK_ADDR_W-1:0] word_addr;
        logic [31:0]            wdata;
    } bank_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
    } bank_rsp_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        uses_rs1;
        logic        uses_rs2;
        logic        uses_rd;
    } fetch_entry_t;

endpackage

`default_nettype wire

// ==== fetch_mem_bank.sv ====
// instruction memory bank
// single port, one word per cycle, registered read data with a
// one cycle valid strobe, host writes through the same port

`default_nettype none

module fetch_mem_bank import fetch_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  bank_req_t req,
    output bank_rsp_t rsp
);

    logic [31:0] mem [BANK_WORDS];
    logic [31:0] rdata;
    logic        rvalid;

    // storage
    always_ff @(posedge clk) begin
        if (req.write)
            mem[req.word_addr] <= req.wdata;
    end

    always_ff @(posedge clk) begin
        if (req.read)
            rdata <= mem[req.word_addr];
    end

    // valid follows the strobe by one cycle
    always_ff @(posedge clk) begin
        if (rst)
            rvalid <= 1'b0;
        else
            rvalid <= req.read;
    end

    assign rsp.valid = rvalid;
    assign rsp.instr = rdata;

endmodule

`default_nettype wire

// ==== fetch_pc_gen.sv ====
// program counter and fetch request generation
// picks the next fetch address, limits fetches in flight to the
// buffer depth and routes fetch and load requests to the banks

`default_nettype none

module fetch_pc_gen import fetch_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        redirect,
    input  wire logic [31:0] redirect_pc,
    input  wire logic        exception,
    input  wire logic        flush,
    input  wire logic        ib_pop,
    input  wire logic        load_en,
    input  wire logic [7:0]  load_addr,
    input  wire logic [31:0] load_data,
    output bank_req_t        bank_req [NUM_BANKS],
    output logic      [31:0] req_pc,
    output logic      [31:0] if_pc
);

    logic [31:0]           next_pc;
    logic [IB_COUNT_W-1:0] inflight_count;
    logic                  issue;

    // loads own the banks for their cycle
    assign issue = ~flush & ~load_en &
                   (inflight_count < IB_COUNT_W'(FETCH_BUFFER_DEPTH));

    // exception beats redirect
    always_comb begin
        if (exception)
            next_pc = RESET_VEC;
        else if (redirect)
            next_pc = redirect_pc;
        else
            next_pc = if_pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (rst)
            if_pc <= RESET_VEC;
        else if (issue | flush)
            if_pc <= {next_pc[31:2], 2'b00};
    end

    always_ff @(posedge clk) begin
        if (issue)
            req_pc <= if_pc;
    end

    // issued and not yet popped, buffered entries included
    always_ff @(posedge clk) begin
        if (rst | flush)
            inflight_count <= '0;
        else if (issue & ~ib_pop)
            inflight_count <= inflight_count + 1'b1;
        else if (~issue & ib_pop)
            inflight_count <= inflight_count - 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // per bank request routing
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req[b].read  = issue & (if_pc[9:8] == BANK_SEL_W'(b));
            bank_req[b].write = load_en &
                                (load_addr[BANK_ADDR_W +: BANK_SEL_W] == BANK_SEL_W'(b));
            bank_req[b].word_addr = load_en ? load_addr[BANK_ADDR_W-1:0] : if_pc[7:2];
            bank_req[b].wdata     = load_data;
        end
    end

endmodule

`default_nettype wire

// ==== fetch_merge_decode.sv ====
// fetch response merge and early decode
// picks the answering bank, drops responses that arrive with a
// flush, and marks which register fields the instruction uses

`default_nettype none

module fetch_merge_decode import fetch_pkg::*; (
    input  wire logic        flush,
    input  bank_rsp_t        bank_rsp [NUM_BANKS],
    input  wire logic [31:0] req_pc,
    output logic             push,
    output fetch_entry_t     push_entry
);

    logic [31:0] instr;
    logic        any_valid;
    logic [4:0]  opcode;
    logic [2:0]  fn3;
    logic [4:0]  rd_field;
    logic        csr_imm_op;
    logic        sys_op;
    logic        link_x0;

    //////////////////////////////////////////////////////////////////////
    // bank merge
    //////////////////////////////////////////////////////////////////////
    // one bank answers at most, so a masked OR is enough
    always_comb begin
        instr     = '0;
        any_valid = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            instr     = instr | ({32{bank_rsp[b].valid}} & bank_rsp[b].instr);
            any_valid = any_valid | bank_rsp[b].valid;
        end
    end

    // stale path data dies here
    assign push = any_valid & ~flush;

    //////////////////////////////////////////////////////////////////////
    // early decode
    //////////////////////////////////////////////////////////////////////
    assign opcode   = instr[6:2];
    assign fn3      = instr[14:12];
    assign rd_field = instr[11:7];

    // csr immediate forms take no rs1
    assign csr_imm_op = (opcode == SYSTEM_T) && fn3[2];
    // ecall, ebreak, xret and friends
    assign sys_op     = (opcode == SYSTEM_T) && (fn3 == 3'b000);
    // jumps that discard the link
    assign link_x0    = (opcode inside {JAL_T, JALR_T}) && (rd_field == 5'd0);

    assign push_entry.pc       = req_pc;
    assign push_entry.instr    = instr;
    assign push_entry.uses_rs1 = !((opcode inside {LUI_T, AUIPC_T, JAL_T, FENCE_T}) ||
                                   csr_imm_op || sys_op);
    assign push_entry.uses_rs2 = opcode inside {BRANCH_T, STORE_T, ARITH_T, AMO_T};
    assign push_entry.uses_rd  = !((opcode inside {BRANCH_T, STORE_T, FENCE_T}) ||
                                   sys_op || link_x0);

endmodule

`default_nettype wire

// ==== fetch_inst_buffer.sv ====
// instruction buffer between fetch and decode
// small circular FIFO, flush empties it, push and pop may
// share a cycle

`default_nettype none

module fetch_inst_buffer import fetch_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   flush,
    input  wire logic   push,
    input  fetch_entry_t push_entry,
    input  wire logic   pop,
    output logic        valid,
    output fetch_entry_t head
);

    fetch_entry_t          entries [FETCH_BUFFER_DEPTH];
    logic [IB_PTR_W-1:0]   wr_ptr;
    logic [IB_PTR_W-1:0]   rd_ptr;
    logic [IB_COUNT_W-1:0] count;
    logic                  pop_taken;

    // pops against an empty buffer are ignored
    assign pop_taken = pop & valid;

    // payload
    always_ff @(posedge clk) begin
        if (push)
            entries[wr_ptr] <= push_entry;
    end

    always_ff @(posedge clk) begin
        if (rst | flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_taken)
                rd_ptr <= rd_ptr + 1'b1;
            if (push & ~pop_taken)
                count <= count + 1'b1;
            else if (~push & pop_taken)
                count <= count - 1'b1;
        end
    end

    assign valid = (count != '0);
    assign head  = entries[rd_ptr];

endmodule

`default_nettype wire

// ==== fetch_top.sv ====
// instruction fetch stage top level
// pc generator, four instruction banks, merge and early decode,
// and the instruction buffer read by decode

`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        redirect,
    input  wire logic [31:0] redirect_pc,
    input  wire logic        exception,
    input  wire logic        load_en,
    input  wire logic [7:0]  load_addr,
    input  wire logic [31:0] load_data,
    input  wire logic        ib_pop,
    output logic             ib_valid,
    output fetch_entry_t     ib_entry,
    output logic      [31:0] if_pc,
    output logic             flush
);

    bank_req_t    bank_req [NUM_BANKS];
    bank_rsp_t    bank_rsp [NUM_BANKS];
    logic [31:0]  req_pc;
    logic         push;
    fetch_entry_t push_entry;
    logic         pop_taken;

    assign flush = redirect | exception;

    // only pops that remove an entry free a fetch slot
    assign pop_taken = ib_pop & ib_valid;

    fetch_pc_gen u_pc_gen (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .exception   (exception),
        .flush       (flush),
        .ib_pop      (pop_taken),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .bank_req    (bank_req),
        .req_pc      (req_pc),
        .if_pc       (if_pc)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        fetch_mem_bank u_bank (
            .clk (clk),
            .rst (rst),
            .req (bank_req[i]),
            .rsp (bank_rsp[i])
        );
    end

    fetch_merge_decode u_merge (
        .flush      (flush),
        .bank_rsp   (bank_rsp),
        .req_pc     (req_pc),
        .push       (push),
        .push_entry (push_entry)
    );

    fetch_inst_buffer u_ib (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (push),
        .push_entry (push_entry),
        .pop        (ib_pop),
        .valid      (ib_valid),
        .head       (ib_entry)
    );

endmodule

`default_nettype wire

// ==== fetch_asserts.sv ====
// instruction buffer assertions
// a full buffer never takes a push, and flush or reset
// leave it empty and without a push in the following cycle

`default_nettype none

module fetch_asserts import fetch_pkg::*; (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  flush,
    input wire logic                  push,
    input wire logic                  valid,
    input wire logic [IB_COUNT_W-1:0] count
);

    // in-flight limit in the pc generator keeps this from happening
    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        !(push && count == IB_COUNT_W'(FETCH_BUFFER_DEPTH)))
        else $error("push into a full instruction buffer");

    // no fetch issues during a flush, so nothing can land right after it
    a_empty_after_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> !valid && !push)
        else $error("instruction buffer valid or pushed after flush");

    a_empty_after_reset: assert property (@(posedge clk) rst |=> !valid && !push)
        else $error("instruction buffer valid or pushed after reset");

endmodule

bind fetch_inst_buffer fetch_asserts u_asserts (
    .clk   (clk),
    .rst   (rst),
    .flush (flush),
    .push  (push),
    .valid (valid),
    .count (count)
);

`default_nettype wire

// ==== fetch_tb.sv ====
// testbench for the instruction fetch stage
// loads random code, then fetches under random pops, redirects and
// exceptions, and checks every popped entry against a reference model

`default_nettype none

module fetch_tb import fetch_pkg::*; ();

    localparam int LOAD_WORDS   = 256;
    localparam int FETCH_CYCLES = 1500;
    // reset, load and fetch phases take about 1760 cycles
    localparam int TIMEOUT_CYCLES = 2500;

    logic         clk;
    logic         rst;
    logic         redirect;
    logic [31:0]  redirect_pc;
    logic         exception;
    logic         load_en;
    logic [7:0]   load_addr;
    logic [31:0]  load_data;
    logic         ib_pop;
    logic         ib_valid;
    fetch_entry_t ib_entry;
    logic [31:0]  if_pc;
    logic         flush;

    integer      seed = 32'h41a8;
    int          errors = 0;
    int          checks = 0;
    int          pops_seen = 0;
    int          cycle_count = 0;
    int          idle_left = 0;
    logic [31:0] model_mem [LOAD_WORDS];
    logic [31:0] exp_pc;
    logic [31:0] exp_if_pc;
    logic        flush_seen;
    logic [4:0]  op_table [12] = '{LUI_T, AUIPC_T, JAL_T, JALR_T, BRANCH_T, LOAD_T,
                                   STORE_T, ARITH_IMM_T, ARITH_T, FENCE_T, SYSTEM_T, AMO_T};

    fetch_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // register use flags {rs1, rs2, rd} as the decode stage expects them
    function automatic logic [2:0] decode_flags(input logic [31:0] instr);
        logic [2:0] fn;
        logic       rs1;
        logic       rs2;
        logic       rd;
        fn  = instr[14:12];
        rs1 = 1'b1;
        rs2 = 1'b0;
        rd  = 1'b1;
        case (instr[6:2])
            LUI_T, AUIPC_T: rs1 = 1'b0;
            JAL_T: begin
                rs1 = 1'b0;
                rd  = (instr[11:7] != 5'd0);
            end
            JALR_T: rd = (instr[11:7] != 5'd0);
            BRANCH_T, STORE_T: begin
                rs2 = 1'b1;
                rd  = 1'b0;
            end
            ARITH_T, AMO_T: rs2 = 1'b1;
            FENCE_T: begin
                rs1 = 1'b0;
                rd  = 1'b0;
            end
            SYSTEM_T: begin
                rs1 = !(fn[2] || fn == 3'b000);
                rd  = (fn != 3'b000);
            end
            default: ;
        endcase
        return {rs1, rs2, rd};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] word;
        logic [31:0] rnd;
        logic [7:0]  addr;
        logic [3:0]  pick;
        logic        exc_now;
        logic        redir_now;
        logic        pop_now;
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        exception   = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        ib_pop      = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // load phase, about half the words get a known opcode group
        for (int i = 0; i < LOAD_WORDS; i++) begin
            addr = 8'(i);
            word = $random(seed);
            pick = 4'($unsigned($random(seed)) % 12);
            if (word[31])
                word[6:0] = {op_table[pick], 2'b11};
            model_mem[addr] = word;
            load_en   <= 1'b1;
            load_addr <= addr;
            load_data <= word;
            @(posedge clk);
        end
        load_en <= 1'b0;
        for (int c = 0; c < FETCH_CYCLES; c++) begin
            rnd       = $random(seed);
            exc_now   = ($unsigned($random(seed)) % 300) == 0;
            redir_now = (($unsigned($random(seed)) % 60) == 0) || (exc_now && rnd[12]);
            // the top 16 words often, so the 1 KiB wrap gets exercised
            if (rnd[1:0] == 2'b00)
                redirect_pc <= {22'd0, 4'hf, rnd[5:2], 2'b00};
            else
                redirect_pc <= {22'd0, rnd[9:2], 2'b00};
            if (exc_now || redir_now) begin
                pop_now = 1'b0;
            end else if (idle_left > 0) begin
                idle_left--;
                pop_now = 1'b0;
            end else if (($unsigned($random(seed)) % 100) == 0) begin
                idle_left = 20;
                pop_now   = 1'b0;
            end else begin
                pop_now = ($unsigned($random(seed)) % 100) < 60;
            end
            redirect  <= redir_now;
            exception <= exc_now;
            ib_pop    <= pop_now;
            @(posedge clk);
        end
        if (pops_seen < 200) begin
            errors++;
            $display("too few entries were popped during the fetch phase (%0d)", pops_seen);
        end
        $display("checks %0d, entries popped %0d, errors %0d", checks, pops_seen, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model, sampled mid cycle
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        logic [31:0] exp_instr;
        logic [2:0]  exp_flags;
        logic        exp_flush;
        logic        exp_issue;
        if (rst) begin
            exp_pc     = RESET_VEC;
            exp_if_pc  = RESET_VEC;
            flush_seen = 1'b0;
        end else begin
            exp_flush = redirect || exception;
            if (flush !== exp_flush) begin
                errors++;
                $display("CHECK FAILED flush expected %h actual %h", exp_flush, flush);
            end
            if (if_pc !== exp_if_pc) begin
                errors++;
                $display("CHECK FAILED if_pc expected %h actual %h", exp_if_pc, if_pc);
            end
            if (flush_seen && ib_valid) begin
                errors++;
                $display("CHECK FAILED ib_valid expected %h actual %h", 1'b0, ib_valid);
            end
            // fetches in flight span from the next pop up to if_pc
            exp_issue = !exp_flush && !load_en &&
                        ((exp_if_pc - exp_pc) < 32'(4 * FETCH_BUFFER_DEPTH));
            if (ib_pop && ib_valid) begin
                exp_instr = model_mem[exp_pc[9:2]];
                exp_flags = decode_flags(exp_instr);
                checks++;
                if (ib_entry.pc !== exp_pc) begin
                    errors++;
                    $display("CHECK FAILED ib_entry.pc expected %h actual %h",
                             exp_pc, ib_entry.pc);
                end
                if (ib_entry.instr !== exp_instr) begin
                    errors++;
                    $display("CHECK FAILED ib_entry.instr expected %h actual %h",
                             exp_instr, ib_entry.instr);
                end
                if ({ib_entry.uses_rs1, ib_entry.uses_rs2, ib_entry.uses_rd} !== exp_flags) begin
                    errors++;
                    $display("CHECK FAILED ib_entry flags expected %h actual %h", exp_flags,
                             {ib_entry.uses_rs1, ib_entry.uses_rs2, ib_entry.uses_rd});
                end
                exp_pc = exp_pc + 32'd4;
                pops_seen++;
            end
            // exception wins over redirect
            if (exp_flush)
                exp_pc = exception ? RESET_VEC : redirect_pc;
            if (exp_flush)
                exp_if_pc = exp_pc;
            else if (exp_issue)
                exp_if_pc = exp_if_pc + 32'd4;
            flush_seen = exp_flush;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== fetch_subsys.f ====
fetch_pkg.sv
fetch_mem_bank.sv
fetch_pc_gen.sv
fetch_merge_decode.sv
fetch_inst_buffer.sv
fetch_top.sv
fetch_asserts.sv
fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fetch stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_tb \
    -f fetch_subsys.f -o fetch_sim

output=$(./obj_dir/fetch_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1
